// ==== Makefile ====
# Verilator flow for the DES core testbench

TOP := des_core_tb

.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert -f build.f --top-module $(TOP) -Mdir obj_dir

# the log decides pass or fail, not the exit code of the simulation
run: compile
	./obj_dir/V$(TOP) > sim.log 2>&1; cat sim.log
	grep -q "All checks passed" sim.log

clean:
	rm -rf obj_dir sim.log

// ==== build.f ====
+incdir+include
design/des_pkg.sv
design/des_round_ctrl.sv
design/des_round_counter.sv
design/des_key_schedule.sv
design/des_feistel_path.sv
design/des_core.sv
tests/des_ref_pkg.sv
tests/des_core_tb.sv

// ==== design/des_core.sv ====
`default_nettype none

`include "des_defines.svh"

module des_core (
    input  wire logic                clock,
    input  wire logic                rst,
    input  wire logic                in_valid,
    input  wire des_pkg::des_block_t plaintext,
    input  wire des_pkg::des_block_t key,
    output logic                     ready,
    output logic                     out_valid,
    output des_pkg::des_block_t      ciphertext
);

    import des_pkg::*;

    des_step_t   step;
    des_subkey_t subkey;
    logic        finish;
    logic        last_round;
    logic        shift_two;

    des_round_ctrl u_ctrl (
        .clock      (clock),
        .rst        (rst),
        .in_valid   (in_valid),
        .last_round (last_round),
        .step       (step),
        .finish     (finish),
        .ready      (ready)
    );

    // round number itself stays inside the counter, seen only in waveforms
    des_round_counter u_counter (
        .step       (step),
        .clock      (clock),
        .rst        (rst),
        .round_idx  (),
        .shift_two  (shift_two),
        .last_round (last_round)
    );

    des_key_schedule u_key (
        .clock     (clock),
        .rst       (rst),
        .step      (step),
        .key       (key),
        .shift_two (shift_two),
        .subkey    (subkey)
    );

    des_feistel_path u_path (
        .clock      (clock),
        .rst        (rst),
        .step       (step),
        .finish     (finish),
        .plaintext  (plaintext),
        .subkey     (subkey),
        .ciphertext (ciphertext),
        .out_valid  (out_valid)
    );

endmodule

`default_nettype wire

// ==== design/des_feistel_path.sv ====
`default_nettype none

`include "des_defines.svh"

module des_feistel_path (
    input  wire logic                clock,
    input  wire logic                rst,
    input  wire des_pkg::des_step_t  step,
    input  wire logic                finish,
    input  wire des_pkg::des_block_t plaintext,
    input  wire des_pkg::des_subkey_t subkey,
    output des_pkg::des_block_t      ciphertext,
    output logic                     out_valid
);

    import des_pkg::*;

    des_lr_t     lr;
    des_lr_t     lr_next;
    des_block_t  ip_blk;
    des_block_t  preout;
    des_block_t  fp_blk;
    des_subkey_t e_out;
    des_subkey_t x_out;
    des_half_t   s_out;
    des_half_t   p_out;

    // initial permutation of the incoming block
    always_comb begin
        for (int i = 0; i < `DES_BLOCK_W; i++) begin
            ip_blk[des_fips_bit(i + 1, `DES_BLOCK_W)] =
                plaintext[des_fips_bit(des_ip[i], `DES_BLOCK_W)];
        end
    end

    // expansion of R, then mix in the round key
    always_comb begin
        for (int i = 0; i < `DES_SUBKEY_W; i++) begin
            e_out[des_fips_bit(i + 1, `DES_SUBKEY_W)] =
                lr.right[des_fips_bit(des_e[i], `DES_HALF_W)];
        end
    end

    assign x_out = e_out ^ subkey;

    // outer bits pick the row, the middle four pick the column
    always_comb begin
        logic [`DES_SBOX_IN_W-1:0] six;
        logic [`DES_SBOX_IN_W-1:0] sidx;
        for (int k = 0; k < `DES_SBOX_COUNT; k++) begin
            six  = x_out[`DES_SUBKEY_W - 1 - `DES_SBOX_IN_W * k -: `DES_SBOX_IN_W];
            sidx = {six[5], six[0], six[4:1]};
            s_out[`DES_HALF_W - 1 - `DES_SBOX_OUT_W * k -: `DES_SBOX_OUT_W] =
                des_sbox[k][sidx];
        end
    end

    always_comb begin
        for (int i = 0; i < `DES_HALF_W; i++) begin
            p_out[des_fips_bit(i + 1, `DES_HALF_W)] =
                s_out[des_fips_bit(des_p[i], `DES_HALF_W)];
        end
    end

    assign lr_next.left  = lr.right;
    assign lr_next.right = lr.left ^ p_out;

    // halves are swapped once more after round 16
    assign preout = {lr.right, lr.left};

    always_comb begin
        for (int i = 0; i < `DES_BLOCK_W; i++) begin
            fp_blk[des_fips_bit(i + 1, `DES_BLOCK_W)] =
                preout[des_fips_bit(des_fp[i], `DES_BLOCK_W)];
        end
    end

    always_ff @(posedge clock) begin
        if (step.load) begin
            lr <= des_lr_t'(ip_blk);
        end else if (step.round) begin
            lr <= lr_next;
        end
    end

    // result holds until the next block finishes
    always_ff @(posedge clock) begin
        if (rst) begin
            ciphertext <= '0;
            out_valid  <= 1'b0;
        end else begin
            out_valid <= finish;
            if (finish) begin
                ciphertext <= fp_blk;
            end
        end
    end

endmodule

`default_nettype wire

// ==== design/des_key_schedule.sv ====
`default_nettype none

`include "des_defines.svh"

module des_key_schedule (
    input  wire logic               clock,
    input  wire logic               rst,
    input  wire des_pkg::des_step_t step,
    input  wire des_pkg::des_block_t key,
    input  wire logic               shift_two,
    output des_pkg::des_subkey_t    subkey
);

    import des_pkg::*;

    des_cd_t cd;
    des_cd_t cd_pc1;
    des_cd_t cd_rot;

    // PC-1 drops the parity bits and splits the key into C and D
    always_comb begin
        for (int i = 0; i < 2 * `DES_CD_W; i++) begin
            cd_pc1[des_fips_bit(i + 1, 2 * `DES_CD_W)] =
                key[des_fips_bit(des_pc1[i], `DES_BLOCK_W)];
        end
    end

    // C and D rotate left on their own, never across the boundary
    always_comb begin
        if (shift_two) begin
            cd_rot.c = {cd.c[`DES_CD_W-3:0], cd.c[`DES_CD_W-1 -: 2]};
            cd_rot.d = {cd.d[`DES_CD_W-3:0], cd.d[`DES_CD_W-1 -: 2]};
        end else begin
            cd_rot.c = {cd.c[`DES_CD_W-2:0], cd.c[`DES_CD_W-1]};
            cd_rot.d = {cd.d[`DES_CD_W-2:0], cd.d[`DES_CD_W-1]};
        end
    end

    // subkey of the current round comes straight from the rotated value
    always_comb begin
        for (int i = 0; i < `DES_SUBKEY_W; i++) begin
            subkey[des_fips_bit(i + 1, `DES_SUBKEY_W)] =
                cd_rot[des_fips_bit(des_pc2[i], 2 * `DES_CD_W)];
        end
    end

    always_ff @(posedge clock) begin
        if (rst) begin
            cd <= '0;
        end else if (step.load) begin
            cd <= cd_pc1;
        end else if (step.round) begin
            cd <= cd_rot;
        end
    end

endmodule

`default_nettype wire

// ==== design/des_pkg.sv ====
`default_nettype none

`include "des_defines.svh"

package des_pkg;

    typedef logic [`DES_BLOCK_W-1:0] des_block_t;
    typedef logic [`DES_HALF_W-1:0] des_half_t;
    typedef logic [`DES_SUBKEY_W-1:0] des_subkey_t;
    typedef logic [`DES_ROUND_W-1:0] round_idx_t;

    typedef struct packed {
        des_half_t left;
        des_half_t right;
    } des_lr_t;

    typedef struct packed {
        logic [`DES_CD_W-1:0] c;
        logic [`DES_CD_W-1:0] d;
    } des_cd_t;

    typedef struct packed {
        logic load;
        logic round;
    } des_step_t;

    // tables use the standard numbering: position 1 is the MSB of the vector
    function automatic int des_fips_bit(input int pos, input int width);
        return width - pos;
    endfunction

    localparam byte unsigned des_ip [`DES_BLOCK_W] = '{
        58, 50, 42, 34, 26, 18, 10, 2, 60, 52, 44, 36, 28, 20, 12, 4,
        62, 54, 46, 38, 30, 22, 14, 6, 64, 56, 48, 40, 32, 24, 16, 8,
        57, 49, 41, 33, 25, 17, 9, 1, 59, 51, 43, 35, 27, 19, 11, 3,
        61, 53, 45, 37, 29, 21, 13, 5, 63, 55, 47, 39, 31, 23, 15, 7
    };

    // inverse of des_ip
    localparam byte unsigned des_fp [`DES_BLOCK_W] = '{
        40, 8, 48, 16, 56, 24, 64, 32, 39, 7, 47, 15, 55, 23, 63, 31,
        38, 6, 46, 14, 54, 22, 62, 30, 37, 5, 45, 13, 53, 21, 61, 29,
        36, 4, 44, 12, 52, 20, 60, 28, 35, 3, 43, 11, 51, 19, 59, 27,
        34, 2, 42, 10, 50, 18, 58, 26, 33, 1, 41, 9, 49, 17, 57, 25
    };

    // expansion of R to 48 bits, edge bits repeat
    localparam byte unsigned des_e [`DES_SUBKEY_W] = '{
        32, 1, 2, 3, 4, 5, 4, 5, 6, 7, 8, 9,
        8, 9, 10, 11, 12, 13, 12, 13, 14, 15, 16, 17,
        16, 17, 18, 19, 20, 21, 20, 21, 22, 23, 24, 25,
        24, 25, 26, 27, 28, 29, 28, 29, 30, 31, 32, 1
    };

    localparam byte unsigned des_p [`DES_HALF_W] = '{
        16, 7, 20, 21, 29, 12, 28, 17, 1, 15, 23, 26, 5, 18, 31, 10,
        2, 8, 24, 14, 32, 27, 3, 9, 19, 13, 30, 6, 22, 11, 4, 25
    };

    // parity bits 8, 16, ... 64 are dropped
    localparam byte unsigned des_pc1 [2*`DES_CD_W] = '{
        57, 49, 41, 33, 25, 17, 9, 1, 58, 50, 42, 34, 26, 18,
        10, 2, 59, 51, 43, 35, 27, 19, 11, 3, 60, 52, 44, 36,
        63, 55, 47, 39, 31, 23, 15, 7, 62, 54, 46, 38, 30, 22,
        14, 6, 61, 53, 45, 37, 29, 21, 13, 5, 28, 20, 12, 4
    };

    localparam byte unsigned des_pc2 [`DES_SUBKEY_W] = '{
        14, 17, 11, 24, 1, 5, 3, 28, 15, 6, 21, 10,
        23, 19, 12, 4, 26, 8, 16, 7, 27, 20, 13, 2,
        41, 52, 31, 37, 47, 55, 30, 40, 51, 45, 33, 48,
        44, 49, 39, 56, 34, 53, 46, 42, 50, 36, 29, 32
    };

    // bit i set when round i (from 0) rotates C/D by two
    localparam logic [`DES_ROUNDS-1:0] des_shift_two = 16'b0111_1110_1111_1100;

    // row-major 4 x 16 per box, index is {row, column}
    localparam logic [`DES_SBOX_OUT_W-1:0] des_sbox [`DES_SBOX_COUNT][64] = '{
        '{14, 4, 13, 1, 2, 15, 11, 8, 3, 10, 6, 12, 5, 9, 0, 7,
          0, 15, 7, 4, 14, 2, 13, 1, 10, 6, 12, 11, 9, 5, 3, 8,
          4, 1, 14, 8, 13, 6, 2, 11, 15, 12, 9, 7, 3, 10, 5, 0,
          15, 12, 8, 2, 4, 9, 1, 7, 5, 11, 3, 14, 10, 0, 6, 13},
        '{15, 1, 8, 14, 6, 11, 3, 4, 9, 7, 2, 13, 12, 0, 5, 10,
          3, 13, 4, 7, 15, 2, 8, 14, 12, 0, 1, 10, 6, 9, 11, 5,
          0, 14, 7, 11, 10, 4, 13, 1, 5, 8, 12, 6, 9, 3, 2, 15,
          13, 8, 10, 1, 3, 15, 4, 2, 11, 6, 7, 12, 0, 5, 14, 9},
        '{10, 0, 9, 14, 6, 3, 15, 5, 1, 13, 12, 7, 11, 4, 2, 8,
          13, 7, 0, 9, 3, 4, 6, 10, 2, 8, 5, 14, 12, 11, 15, 1,
          13, 6, 4, 9, 8, 15, 3, 0, 11, 1, 2, 12, 5, 10, 14, 7,
          1, 10, 13, 0, 6, 9, 8, 7, 4, 15, 14, 3, 11, 5, 2, 12},
        '{7, 13, 14, 3, 0, 6, 9, 10, 1, 2, 8, 5, 11, 12, 4, 15,
          13, 8, 11, 5, 6, 15, 0, 3, 4, 7, 2, 12, 1, 10, 14, 9,
          10, 6, 9, 0, 12, 11, 7, 13, 15, 1, 3, 14, 5, 2, 8, 4,
          3, 15, 0, 6, 10, 1, 13, 8, 9, 4, 5, 11, 12, 7, 2, 14},
        '{2, 12, 4, 1, 7, 10, 11, 6, 8, 5, 3, 15, 13, 0, 14, 9,
          14, 11, 2, 12, 4, 7, 13, 1, 5, 0, 15, 10, 3, 9, 8, 6,
          4, 2, 1, 11, 10, 13, 7, 8, 15, 9, 12, 5, 6, 3, 0, 14,
          11, 8, 12, 7, 1, 14, 2, 13, 6, 15, 0, 9, 10, 4, 5, 3},
        '{12, 1, 10, 15, 9, 2, 6, 8, 0, 13, 3, 4, 14, 7, 5, 11,
          10, 15, 4, 2, 7, 12, 9, 5, 6, 1, 13, 14, 0, 11, 3, 8,
          9, 14, 15, 5, 2, 8, 12, 3, 7, 0, 4, 10, 1, 13, 11, 6,
          4, 3, 2, 12, 9, 5, 15, 10, 11, 14, 1, 7, 6, 0, 8, 13},
        '{4, 11, 2, 14, 15, 0, 8, 13, 3, 12, 9, 7, 5, 10, 6, 1,
          13, 0, 11, 7, 4, 9, 1, 10, 14, 3, 5, 12, 2, 15, 8, 6,
          1, 4, 11, 13, 12, 3, 7, 14, 10, 15, 6, 8, 0, 5, 9, 2,
          6, 11, 13, 8, 1, 4, 10, 7, 9, 5, 0, 15, 14, 2, 3, 12},
        '{13, 2, 8, 4, 6, 15, 11, 1, 10, 9, 3, 14, 5, 0, 12, 7,
          1, 15, 13, 8, 10, 3, 7, 4, 12, 5, 6, 11, 0, 14, 9, 2,
          7, 11, 4, 1, 9, 12, 14, 2, 0, 6, 10, 13, 15, 3, 5, 8,
          2, 1, 14, 7, 4, 10, 8, 13, 15, 12, 9, 0, 3, 5, 6, 11}
    };

endpackage

`default_nettype wire

// ==== design/des_round_counter.sv ====
`default_nettype none

`include "des_defines.svh"

module des_round_counter (
    input  wire des_pkg::des_step_t step,
    input  wire logic               clock,
    input  wire logic               rst,
    output des_pkg::round_idx_t     round_idx,
    output logic                    shift_two,
    output logic                    last_round
);

    import des_pkg::*;

    // index of the round being applied in the current cycle
    always_ff @(posedge clock) begin
        if (rst) begin
            round_idx <= '0;
        end else if (step.load) begin
            round_idx <= '0;
        end else if (step.round) begin
            // wraps back to zero after round 15
            round_idx <= round_idx + 1'b1;
        end
    end

    // rotation amount for this round, feeds the key schedule directly
    assign shift_two = des_shift_two[round_idx];

    assign last_round = (round_idx == round_idx_t'(`DES_ROUNDS - 1));

endmodule

`default_nettype wire

// ==== design/des_round_ctrl.sv ====
`default_nettype none

`include "des_defines.svh"

module des_round_ctrl (
    input  wire logic          clock,
    input  wire logic          rst,
    input  wire logic          in_valid,
    input  wire logic          last_round,
    output des_pkg::des_step_t step,
    output logic               finish,
    output logic               ready
);

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_ROUNDS,
        ST_FINISH
    } state_t;

    state_t state;
    state_t state_next;
    logic   accept;

    // a block is taken only while idle, anything else on in_valid is dropped
    assign ready  = (state == ST_IDLE);
    assign accept = in_valid && ready;

    always_comb begin
        state_next = state;
        case (state)
            ST_IDLE: begin
                if (accept) begin
                    state_next = ST_ROUNDS;
                end
            end
            // counter reports index 15 during the sixteenth round
            ST_ROUNDS: begin
                if (last_round) begin
                    state_next = ST_FINISH;
                end
            end
            ST_FINISH: begin
                state_next = ST_IDLE;
            end
            default: begin
                state_next = ST_IDLE;
            end
        endcase
    end

    always_ff @(posedge clock) begin
        if (rst) begin
            state <= ST_IDLE;
        end else begin
            state <= state_next;
        end
    end

    assign step.load  = accept;
    assign step.round = (state == ST_ROUNDS);
    assign finish     = (state == ST_FINISH);

endmodule

`default_nettype wire

// ==== include/des_defines.svh ====
`ifndef DES_DEFINES_SVH
`define DES_DEFINES_SVH

// data block, also the width of the raw key
`define DES_BLOCK_W 64

// one Feistel half
`define DES_HALF_W 32

// per-round subkey after PC-2
`define DES_SUBKEY_W 48

// each of the C and D key halves
`define DES_CD_W 28

// round count and the width of the round index
`define DES_ROUNDS 16
`define DES_ROUND_W 4

// substitution boxes, 6 bits in and 4 bits out
`define DES_SBOX_COUNT 8
`define DES_SBOX_IN_W 6
`define DES_SBOX_OUT_W 4

`endif

// ==== tests/des_core_tb.sv ====
`default_nettype none

module des_core_tb;

    timeunit 1ns;
    timeprecision 1ps;

    import des_pkg::*;
    import des_ref_pkg::*;

    localparam int clk_period = 100;
    localparam int latency = 17;
    localparam int random_blocks = 20;
    localparam int total_blocks = random_blocks + 2;
    localparam int idle_edges = 1000;
    localparam int watchdog_cycles = (10 + 24 * 20) * 2;

    logic       clock;
    logic       rst;
    logic       in_valid;
    des_block_t plaintext;
    des_block_t key;
    logic       ready;
    logic       out_valid;
    des_block_t ciphertext;

    // expected result offered alongside each block, head of the scoreboard for checks
    des_block_t exp_in;
    des_block_t exp_head;
    des_block_t scoreboard [$];
    int         edges_since_accept;
    int         accepted;
    int         pulses;
    int         errors = 0;

    des_core u_des_core (
        .clock      (clock),
        .rst        (rst),
        .in_valid   (in_valid),
        .plaintext  (plaintext),
        .key        (key),
        .ready      (ready),
        .out_valid  (out_valid),
        .ciphertext (ciphertext)
    );

    initial begin
        clock = 1'b0;
        forever #(clk_period / 2) clock = ~clock;
    end

    // tracks accepted blocks and the cycles since the last one
    always @(posedge clock) begin
        if (rst) begin
            scoreboard.delete();
            edges_since_accept <= idle_edges;
            accepted <= 0;
            pulses <= 0;
            exp_head <= '0;
        end else begin
            if (out_valid) begin
                pulses <= pulses + 1;
                if (scoreboard.size() > 0) void'(scoreboard.pop_front());
            end
            if (in_valid && ready) begin
                scoreboard.push_back(exp_in);
                accepted <= accepted + 1;
                edges_since_accept <= 0;
            end else if (edges_since_accept < idle_edges) begin
                edges_since_accept <= edges_since_accept + 1;
            end
            exp_head <= (scoreboard.size() > 0) ? scoreboard[0] : '0;
        end
    end

    reset_state_ok: assert property (@(posedge clock)
        $past(rst) |-> (ready && !out_valid && ciphertext == '0))
        else begin
            errors++;
            $display("error at %0t: ready got %b expected 1, out_valid got %b expected 0",
                     $time, $sampled(ready), $sampled(out_valid));
            $display("error at %0t: ciphertext got %h expected %h",
                     $time, $sampled(ciphertext), 64'h0);
        end

    result_matches: assert property (@(posedge clock) disable iff (rst)
        out_valid |-> ciphertext == exp_head)
        else begin
            errors++;
            $display("error at %0t: ciphertext got %h expected %h",
                     $time, $sampled(ciphertext), $sampled(exp_head));
        end

    // result stays put between pulses
    ciphertext_held: assert property (@(posedge clock) disable iff (rst)
        !out_valid && !$past(rst) |-> $stable(ciphertext))
        else begin
            errors++;
            $display("error at %0t: ciphertext got %h expected %h",
                     $time, $sampled(ciphertext), $past(ciphertext));
        end

    result_was_expected: assert property (@(posedge clock) disable iff (rst)
        out_valid |-> accepted > pulses)
        else begin
            errors++;
            $display("out_valid pulsed at %0t with no accepted block waiting", $time);
        end

    // also limits the pulse to one cycle, the count moves past 17 right after
    latency_exact: assert property (@(posedge clock) disable iff (rst)
        out_valid |-> edges_since_accept == latency)
        else begin
            errors++;
            $display("error at %0t: out_valid latency got %0d expected %0d",
                     $time, $sampled(edges_since_accept), latency);
        end

    latency_reached: assert property (@(posedge clock) disable iff (rst)
        edges_since_accept == latency |-> out_valid)
        else begin
            errors++;
            $display("error at %0t: out_valid got 0 expected 1", $time);
        end

    ready_low_while_busy: assert property (@(posedge clock) disable iff (rst)
        edges_since_accept < latency |-> !ready)
        else begin
            errors++;
            $display("error at %0t: ready got 1 expected 0", $time);
        end

    // holds in_valid until the DUT takes the block, returns on the accepting edge
    task automatic offer_block(input des_block_t blk_key, input des_block_t blk_pt,
                               input des_block_t expected);
        key <= blk_key;
        plaintext <= blk_pt;
        exp_in <= expected;
        in_valid <= 1'b1;
        do begin
            @(posedge clock);
        end while (!ready);
        in_valid <= 1'b0;
    endtask

    task automatic await_result();
        do begin
            @(posedge clock);
        end while (!out_valid);
    endtask

    // junk blocks while busy, the last one lands on the finish cycle
    task automatic drive_busy_pulses();
        repeat (2) @(posedge clock);
        in_valid <= 1'b1;
        key <= {$urandom(), $urandom()};
        plaintext <= {$urandom(), $urandom()};
        exp_in <= '1;
        @(posedge clock);
        in_valid <= 1'b0;
        repeat (13) @(posedge clock);
        in_valid <= 1'b1;
        plaintext <= {$urandom(), $urandom()};
        @(posedge clock);
        in_valid <= 1'b0;
        await_result();
    endtask

    initial begin
        des_block_t k;
        des_block_t p;
        int         count_errors;
        count_errors = 0;
        void'($urandom(32'hb9cf));
        rst = 1'b1;
        in_valid = 1'b0;
        plaintext = '0;
        key = '0;
        exp_in = '0;
        repeat (10) @(posedge clock);
        rst <= 1'b0;
        @(posedge clock);
        offer_block(64'h133457799BBCDFF1, 64'h0123456789ABCDEF, 64'h85E813540F0AB405);
        await_result();
        offer_block('0, '0, 64'h8CA64DE9C1B123A7);
        await_result();
        for (int i = 0; i < random_blocks; i++) begin
            k = {$urandom(), $urandom()};
            p = {$urandom(), $urandom()};
            offer_block(k, p, des_encrypt(k, p));
            case (i % 4)
                1: drive_busy_pulses();
                // next block is driven on the edge that raises out_valid
                2: repeat (latency) @(posedge clock);
                default: await_result();
            endcase
        end
        repeat (4) @(posedge clock);
        if (accepted != total_blocks || pulses != accepted) begin
            count_errors++;
            $display("wrong block count: %0d offered, %0d accepted, %0d results",
                     total_blocks, accepted, pulses);
        end
        $display("summary: %0d check errors, %0d count errors, %0d blocks, %0d results",
                 errors, count_errors, accepted, pulses);
        if (errors == 0 && count_errors == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

    initial begin
        #(watchdog_cycles * clk_period);
        $display("timeout after %0d cycles, the DUT stopped producing results",
                 watchdog_cycles);
        $display("Checks failed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== tests/des_ref_pkg.sv ====
`default_nettype none

package des_ref_pkg;

    localparam int ref_ip [64] = '{
        58, 50, 42, 34, 26, 18, 10, 2, 60, 52, 44, 36, 28, 20, 12, 4,
        62, 54, 46, 38, 30, 22, 14, 6, 64, 56, 48, 40, 32, 24, 16, 8,
        57, 49, 41, 33, 25, 17, 9, 1, 59, 51, 43, 35, 27, 19, 11, 3,
        61, 53, 45, 37, 29, 21, 13, 5, 63, 55, 47, 39, 31, 23, 15, 7
    };
    localparam int ref_pc1 [56] = '{
        57, 49, 41, 33, 25, 17, 9, 1, 58, 50, 42, 34, 26, 18, 10, 2, 59, 51, 43,
        35, 27, 19, 11, 3, 60, 52, 44, 36, 63, 55, 47, 39, 31, 23, 15, 7, 62, 54,
        46, 38, 30, 22, 14, 6, 61, 53, 45, 37, 29, 21, 13, 5, 28, 20, 12, 4
    };
    localparam int ref_pc2 [48] = '{
        14, 17, 11, 24, 1, 5, 3, 28, 15, 6, 21, 10, 23, 19, 12, 4, 26, 8, 16, 7,
        27, 20, 13, 2, 41, 52, 31, 37, 47, 55, 30, 40, 51, 45, 33, 48, 44, 49, 39,
        56, 34, 53, 46, 42, 50, 36, 29, 32
    };
    localparam int ref_p [32] = '{
        16, 7, 20, 21, 29, 12, 28, 17, 1, 15, 23, 26, 5, 18, 31, 10,
        2, 8, 24, 14, 32, 27, 3, 9, 19, 13, 30, 6, 22, 11, 4, 25
    };
    localparam int ref_shifts [16] = '{1, 1, 2, 2, 2, 2, 2, 2, 1, 2, 2, 2, 2, 2, 2, 1};

    // one box per word, 64 nibbles in {row, column} order, first entry at the top
    localparam logic [255:0] ref_sbox [8] = '{
        256'hE4D12FB83A6C5907_0F74E2D1A6CB9538_41E8D62BFC973A50_FC8249175B3EA06D,
        256'hF18E6B34972DC05A_3D47F28EC01A69B5_0E7BA4D158C6932F_D8A13F42B67C05E9,
        256'hA09E63F51DC7B428_D709346A285ECBF1_D6498F30B12C5AE7_1AD069874FE3B52C,
        256'h7DE3069A1285BC4F_D8B56F03472C1AE9_A690CB7DF13E5284_3F06A1D8945BC72E,
        256'h2C417AB6853FD0E9_EB2C47D150FA3986_421BAD78F9C5630E_B8C71E2D6F09A453,
        256'hC1AF92680D34E75B_AF427C9561DE0B38_9EF528C3704A1DB6_432C95FABE17608D,
        256'h4B2EF08D3C975A61_D0B7491AE35C2F86_14BDC37EAF680592_6BD814A7950FE23C,
        256'hD2846FB1A93E50C7_1FD8A374C56B0E92_7B419CE206ADF358_21E74A8DFC90356B
    };

    // E table follows a fixed pattern: groups of six overlapping by one bit
    function automatic int e_source(input int pos);
        return ((pos / 6) * 4 + pos % 6 + 31) % 32 + 1;
    endfunction

    function automatic logic [3:0] sbox_lookup(input int box, input logic [5:0] six);
        int idx;
        idx = int'({six[5], six[0], six[4:1]});
        return ref_sbox[box][255 - 4 * idx -: 4];
    endfunction

    function automatic logic [63:0] des_encrypt(input logic [63:0] key, input logic [63:0] pt);
        logic [55:0] cd;
        logic [27:0] c;
        logic [27:0] d;
        logic [47:0] x;
        logic [63:0] perm;
        logic [63:0] ct;
        logic [31:0] l;
        logic [31:0] r;
        logic [31:0] s;
        logic [31:0] f;
        for (int i = 0; i < 56; i++) cd[55 - i] = key[64 - ref_pc1[i]];
        c = cd[55:28];
        d = cd[27:0];
        for (int i = 0; i < 64; i++) perm[63 - i] = pt[64 - ref_ip[i]];
        l = perm[63:32];
        r = perm[31:0];
        for (int n = 0; n < 16; n++) begin
            c = (c << ref_shifts[n]) | (c >> (28 - ref_shifts[n]));
            d = (d << ref_shifts[n]) | (d >> (28 - ref_shifts[n]));
            cd = {c, d};
            for (int i = 0; i < 48; i++) x[47 - i] = r[32 - e_source(i)] ^ cd[56 - ref_pc2[i]];
            for (int b = 0; b < 8; b++) s[31 - 4 * b -: 4] = sbox_lookup(b, x[47 - 6 * b -: 6]);
            for (int i = 0; i < 32; i++) f[31 - i] = s[32 - ref_p[i]];
            {l, r} = {r, l ^ f};
        end
        perm = {r, l};
        // final permutation scatters through the IP table instead of a table of its own
        for (int i = 0; i < 64; i++) ct[64 - ref_ip[i]] = perm[63 - i];
        return ct;
    endfunction

endpackage

`default_nettype wire
